// File: Makefile
VERILATOR = verilator
FLAGS = --timing
TOP = CpuTb
FILELIST = verilog.f
BUILD = obj_dir
LOG = sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	./$(BUILD)/$(TOP) | tee $(LOG)
	@if grep -q "Testbench failed" $(LOG); then exit 1; fi
	@grep -q "Testbench passed" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// File: hw/Alu.sv
`timescale 1ns/1ps

module Alu (
	input  CpuPkg::word_t  a,
	input  CpuPkg::word_t  b,
	input  logic [4:0]     shamt,
	input  CpuPkg::aluOp_t op,
	output CpuPkg::word_t  result,
	output logic           zero
);
	import CpuPkg::*;

	logic lessThan;

	// Signed compare for slt and slti
	assign lessThan = $signed(a) < $signed(b);

	always_comb begin
		case (op)
			AluAdd: result = a + b;
			AluSub: result = a - b;
			AluAnd: result = a & b;
			AluOr:  result = a | b;
			AluXor: result = a ^ b;
			AluSlt: result = {{(DataWidth-1){1'b0}}, lessThan};
			// Shifts act on b, as in MIPS
			AluSll: result = b << shamt;
			AluSrl: result = b >> shamt;
			default: result = '0;
		endcase
	end

	// Equality test for beq and bne
	assign zero = (result == '0);

endmodule

// File: hw/Cpu.sv
`timescale 1ns/1ps

module Cpu #(
	parameter int MemWords = 256
) (
	input  logic          clk,
	input  logic          rst,
	input  logic          extMode,
	input  logic          extWrite,
	input  CpuPkg::word_t extAddress,
	input  CpuPkg::word_t extData,
	output CpuPkg::word_t extDataOut
);
	import CpuPkg::*;

	// Fetch
	word_t pc, fetchData, fetchPc;
	logic fetchValid;

	// Decode
	word_t decInstr, decImm, decRs, decRt;
	regAddr_t decDest;
	aluOp_t decAluOp;
	logic decUseImm, decSignExt, decRegWrite, decDestIsRd, decMemWrite;
	wbSel_t decWbSel;
	branchMode_t decBranchMode;

	// Execute stage registers
	word_t exPc, exRs, exRt, exImm;
	regAddr_t exRsAddr, exRtAddr, exDest;
	logic [4:0] exShamt;
	logic [25:0] exJumpIndex;
	aluOp_t exAluOp;
	logic exUseImm, exRegWrite, exMemWrite;
	wbSel_t exWbSel;
	branchMode_t exBranchMode;

	// Execute
	word_t rsFwd, rtFwd, aluB, aluResult;
	logic aluZero;

	// Memory port and write-back
	word_t dataAddr, dataIn, dataOut;
	logic dataWrite;
	word_t wbAlu, wbData;
	regAddr_t wbDest;
	logic wbRegWrite;
	wbSel_t wbWbSel;

	PcUnit PcUnit_inst (
		.clk(clk), .rst(rst), .branchMode(exBranchMode), .zero(aluZero),
		.instrPc(exPc), .offset(exImm[15:0]), .jumpIndex(exJumpIndex), .pc(pc)
	);

	UnifiedMemory #(.MemWords(MemWords)) UnifiedMemory_inst (
		.clk(clk), .fetchAddr(pc), .fetchData(fetchData), .dataAddr(dataAddr),
		.dataWrite(dataWrite), .dataIn(dataIn), .dataOut(dataOut)
	);

	// First word after reset is stale, decode it as a no-op
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			fetchValid <= 1'b0;
			fetchPc <= '0;
		end else begin
			fetchValid <= 1'b1;
			fetchPc <= pc;
		end
	end

	assign decInstr = fetchValid ? fetchData : '0;

	Decoder Decoder_inst (
		.instr(decInstr), .aluOp(decAluOp), .useImm(decUseImm), .signExt(decSignExt),
		.regWrite(decRegWrite), .destIsRd(decDestIsRd), .memWrite(decMemWrite),
		.wbSel(decWbSel), .branchMode(decBranchMode)
	);

	RegisterFile RegisterFile_inst (
		.clk(clk), .rst(rst), .rsAddr(decInstr[25:21]), .rtAddr(decInstr[20:16]),
		.writeAddr(wbDest), .writeEn(wbRegWrite), .writeData(wbData),
		.rsData(decRs), .rtData(decRt)
	);

	assign decImm = decSignExt ? {{16{decInstr[15]}}, decInstr[15:0]}
		: {16'b0, decInstr[15:0]};
	// rd for R-type, rt otherwise
	assign decDest = decDestIsRd ? decInstr[15:11] : decInstr[20:16];

	// Decode to execute, control
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			exAluOp <= AluAdd;
			exUseImm <= 1'b0;
			exRegWrite <= 1'b0;
			exMemWrite <= 1'b0;
			exWbSel <= WbAlu;
			exBranchMode <= BrNone;
		end else begin
			exAluOp <= decAluOp;
			exUseImm <= decUseImm;
			exRegWrite <= decRegWrite;
			exMemWrite <= decMemWrite;
			exWbSel <= decWbSel;
			exBranchMode <= decBranchMode;
		end
	end

	// Decode to execute, payload
	always_ff @(posedge clk) begin
		exPc <= fetchPc;
		exRs <= decRs;
		exRt <= decRt;
		exImm <= decImm;
		exRsAddr <= decInstr[25:21];
		exRtAddr <= decInstr[20:16];
		exDest <= decDest;
		exShamt <= decInstr[10:6];
		exJumpIndex <= decInstr[25:0];
	end

	// Forward the write-back value, covers loads too
	assign rsFwd = (wbRegWrite && wbDest != RegZero && wbDest == exRsAddr) ? wbData : exRs;
	assign rtFwd = (wbRegWrite && wbDest != RegZero && wbDest == exRtAddr) ? wbData : exRt;
	assign aluB = exUseImm ? exImm : rtFwd;

	Alu Alu_inst (
		.a(rsFwd), .b(aluB), .shamt(exShamt), .op(exAluOp),
		.result(aluResult), .zero(aluZero)
	);

	// Host owns the data port in external mode
	assign dataAddr = extMode ? extAddress : aluResult;
	assign dataIn = extMode ? extData : rtFwd;
	assign dataWrite = extMode ? extWrite : exMemWrite;
	assign extDataOut = extMode ? dataOut : '0;

	// Execute to write-back
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			wbRegWrite <= 1'b0;
			wbWbSel <= WbAlu;
		end else begin
			wbRegWrite <= exRegWrite;
			wbWbSel <= exWbSel;
		end
	end

	always_ff @(posedge clk) begin
		wbAlu <= aluResult;
		wbDest <= exDest;
	end

	// Load data arrives straight from the memory output register
	assign wbData = (wbWbSel == WbMem) ? dataOut : wbAlu;

endmodule

// File: hw/CpuPkg.sv
package CpuPkg;

	// Machine word and register index widths
	localparam int DataWidth = 32;
	localparam int RegAddrWidth = 5;

	typedef logic [DataWidth-1:0] word_t;
	typedef logic [RegAddrWidth-1:0] regAddr_t;

	// Hardwired zero register
	localparam regAddr_t RegZero = '0;

	// Primary opcodes, MIPS encoding
	typedef enum logic [5:0] {
		OpRtype = 6'h00,
		OpJ     = 6'h02,
		OpBeq   = 6'h04,
		OpBne   = 6'h05,
		OpAddi  = 6'h08,
		OpSlti  = 6'h0a,
		OpAndi  = 6'h0c,
		OpOri   = 6'h0d,
		OpLw    = 6'h23,
		OpSw    = 6'h2b
	} opcode_t;

	// R-type funct field
	typedef enum logic [5:0] {
		FnSll = 6'h00,
		FnSrl = 6'h02,
		FnAdd = 6'h20,
		FnSub = 6'h22,
		FnAnd = 6'h24,
		FnOr  = 6'h25,
		FnXor = 6'h26,
		FnSlt = 6'h2a
	} funct_t;

	// ALU operations
	typedef enum logic [3:0] {
		AluAdd,
		AluSub,
		AluAnd,
		AluOr,
		AluXor,
		AluSlt,
		AluSll,
		AluSrl
	} aluOp_t;

	// Write-back source
	typedef enum logic {
		WbAlu,
		WbMem
	} wbSel_t;

	// Branch handling in execute
	typedef enum logic [1:0] {
		BrNone,
		BrEq,
		BrNe,
		BrJump
	} branchMode_t;

endpackage

// File: hw/Decoder.sv
`timescale 1ns/1ps

module Decoder (
	input  CpuPkg::word_t       instr,
	output CpuPkg::aluOp_t      aluOp,
	output logic                useImm,
	output logic                signExt,
	output logic                regWrite,
	output logic                destIsRd,
	output logic                memWrite,
	output CpuPkg::wbSel_t      wbSel,
	output CpuPkg::branchMode_t branchMode
);
	import CpuPkg::*;

	opcode_t opcode;
	funct_t funct;

	assign opcode = opcode_t'(instr[31:26]);
	assign funct = funct_t'(instr[5:0]);

	always_comb begin
		// Default is a no-op
		aluOp = AluAdd;
		useImm = 1'b0;
		signExt = 1'b0;
		regWrite = 1'b0;
		destIsRd = 1'b0;
		memWrite = 1'b0;
		wbSel = WbAlu;
		branchMode = BrNone;

		case (opcode)
			OpRtype: begin
				destIsRd = 1'b1;
				regWrite = 1'b1;
				case (funct)
					FnSll: aluOp = AluSll;
					FnSrl: aluOp = AluSrl;
					FnAdd: aluOp = AluAdd;
					FnSub: aluOp = AluSub;
					FnAnd: aluOp = AluAnd;
					FnOr:  aluOp = AluOr;
					FnXor: aluOp = AluXor;
					FnSlt: aluOp = AluSlt;
					// Unknown funct, drop the write
					default: regWrite = 1'b0;
				endcase
			end
			OpAddi, OpSlti: begin
				aluOp = (opcode == OpSlti) ? AluSlt : AluAdd;
				useImm = 1'b1;
				signExt = 1'b1;
				regWrite = 1'b1;
			end
			OpAndi, OpOri: begin
				// Logical immediates zero-extend
				aluOp = (opcode == OpOri) ? AluOr : AluAnd;
				useImm = 1'b1;
				regWrite = 1'b1;
			end
			OpLw: begin
				useImm = 1'b1;
				signExt = 1'b1;
				regWrite = 1'b1;
				wbSel = WbMem;
			end
			OpSw: begin
				useImm = 1'b1;
				signExt = 1'b1;
				memWrite = 1'b1;
			end
			OpBeq, OpBne: begin
				// Subtract so the zero flag compares rs and rt
				aluOp = AluSub;
				signExt = 1'b1;
				branchMode = (opcode == OpBeq) ? BrEq : BrNe;
			end
			OpJ: begin
				branchMode = BrJump;
			end
			default: begin
			end
		endcase
	end

endmodule

// File: hw/PcUnit.sv
`timescale 1ns/1ps

module PcUnit (
	input  logic                clk,
	input  logic                rst,
	input  CpuPkg::branchMode_t branchMode,
	input  logic                zero,
	input  CpuPkg::word_t       instrPc,
	input  logic [15:0]         offset,
	input  logic [25:0]         jumpIndex,
	output CpuPkg::word_t       pc
);
	import CpuPkg::*;

	word_t linkPc;
	word_t branchTarget;
	word_t jumpTarget;
	word_t nextPc;
	logic taken;

	// Targets are relative to the instruction after the branch
	assign linkPc = instrPc + 32'd4;
	assign branchTarget = linkPc + {{14{offset[15]}}, offset, 2'b00};
	assign jumpTarget = {linkPc[31:28], jumpIndex, 2'b00};

	// Resolve using the execute-stage flag
	always_comb begin
		case (branchMode)
			BrEq:    taken = zero;
			BrNe:    taken = ~zero;
			BrJump:  taken = 1'b1;
			default: taken = 1'b0;
		endcase
	end

	always_comb begin
		if (!taken) begin
			nextPc = pc + 32'd4;
		end else if (branchMode == BrJump) begin
			nextPc = jumpTarget;
		end else begin
			nextPc = branchTarget;
		end
	end

	// No flush, the two fetches already in flight still run
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			pc <= '0;
		end else begin
			pc <= nextPc;
		end
	end

endmodule

// File: hw/RegisterFile.sv
`timescale 1ns/1ps

module RegisterFile (
	input  logic             clk,
	input  logic             rst,
	input  CpuPkg::regAddr_t rsAddr,
	input  CpuPkg::regAddr_t rtAddr,
	input  CpuPkg::regAddr_t writeAddr,
	input  logic             writeEn,
	input  CpuPkg::word_t    writeData,
	output CpuPkg::word_t    rsData,
	output CpuPkg::word_t    rtData
);
	import CpuPkg::*;

	word_t regs [2**RegAddrWidth];
	logic doWrite;

	// Register 0 is never stored
	assign doWrite = writeEn && (writeAddr != RegZero);

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			for (int i = 0; i < 2**RegAddrWidth; i++) begin
				regs[i] <= '0;
			end
		end else if (doWrite) begin
			regs[writeAddr] <= writeData;
		end
	end

	// Reads see a same-cycle write
	assign rsData = (rsAddr == RegZero) ? '0 :
		(doWrite && writeAddr == rsAddr) ? writeData : regs[rsAddr];
	assign rtData = (rtAddr == RegZero) ? '0 :
		(doWrite && writeAddr == rtAddr) ? writeData : regs[rtAddr];

endmodule

// File: hw/UnifiedMemory.sv
`timescale 1ns/1ps

module UnifiedMemory #(
	parameter int MemWords = 256
) (
	input  logic          clk,
	input  CpuPkg::word_t fetchAddr,
	output CpuPkg::word_t fetchData,
	input  CpuPkg::word_t dataAddr,
	input  logic          dataWrite,
	input  CpuPkg::word_t dataIn,
	output CpuPkg::word_t dataOut
);
	import CpuPkg::*;

	localparam int IdxWidth = $clog2(MemWords);

	word_t mem [MemWords];
	logic [IdxWidth-1:0] fetchIdx;
	logic [IdxWidth-1:0] dataIdx;

	// Byte address in, word index out, wraps at depth
	assign fetchIdx = fetchAddr[IdxWidth+1:2];
	assign dataIdx = dataAddr[IdxWidth+1:2];

	// Instruction port, read only
	always_ff @(posedge clk) begin
		fetchData <= mem[fetchIdx];
	end

	// Data port, old contents on a write cycle
	always_ff @(posedge clk) begin
		if (dataWrite) begin
			mem[dataIdx] <= dataIn;
		end
		dataOut <= mem[dataIdx];
	end

endmodule

// File: tests/CpuChecker.sv
`timescale 1ns/1ps

module CpuChecker (
	input  logic          clk,
	input  logic          extMode,
	input  CpuPkg::word_t extDataOut,
	input  logic          checkEn,
	input  logic          testDone,
	output int            passCount,
	output int            failCount
);
	import CpuPkg::*;

	string names[$];
	word_t expAddr[$];
	word_t expWord[$];
	int testIdx = 0;
	int expIdx = 0;
	int wrongWords = 0;
	int passes = 0;
	int fails = 0;
	// Data of last cycle's read is due now
	logic pending = 1'b0;
	logic lowModeBad = 1'b0;

	assign passCount = passes;
	assign failCount = fails;

	initial begin
		int fd;
		int n;
		int count;
		string tag;
		string rest;
		word_t addr;
		word_t value;
		fd = $fopen("tests/cpu_testdata.txt", "r");
		if (fd == 0) begin
			$display("Checker could not open tests/cpu_testdata.txt");
		end else begin
			while ($fscanf(fd, "%s", tag) == 1) begin
				if (tag.substr(0, 0) == "#") begin
					n = $fgets(rest, fd);
				end else if (tag == "test") begin
					n = $fscanf(fd, "%s", rest);
					names.push_back(rest);
				end else if (tag == "budget") begin
					n = $fscanf(fd, "%d", count);
				end else if (tag == "prog") begin
					// Skip the program words
					n = $fscanf(fd, "%h %d", addr, count);
					for (int i = 0; i < count; i++) begin
						n = $fscanf(fd, "%h", value);
					end
				end else if (tag == "expect") begin
					n = $fscanf(fd, "%d", count);
					for (int i = 0; i < count; i++) begin
						n = $fscanf(fd, "%h %h", addr, value);
						expAddr.push_back(addr);
						expWord.push_back(value);
					end
				end
			end
			$fclose(fd);
		end
	end

	function automatic string testName();
		if (testIdx < names.size()) begin
			return names[testIdx];
		end
		return "unknown";
	endfunction

	always @(posedge clk) begin
		string reason;
		// Port reads zero while the core owns it
		if (!extMode && extDataOut != '0) begin
			lowModeBad <= 1'b1;
		end
		if (pending) begin
			if (expIdx >= expWord.size()) begin
				$display("%s: more reads than expected words", testName());
				wrongWords <= wrongWords + 1;
			end else if (extDataOut !== expWord[expIdx]) begin
				$display("[ERROR] %s: word at %h expected %h actual %h", testName(),
					expAddr[expIdx], expWord[expIdx], extDataOut);
				wrongWords <= wrongWords + 1;
			end
			expIdx <= expIdx + 1;
		end
		pending <= checkEn;
		if (testDone) begin
			reason = "";
			if (testIdx >= names.size()) begin
				reason = "no expected data for this test";
			end else if (lowModeBad) begin
				reason = "extDataOut was not zero while extMode was low";
			end else if (wrongWords != 0) begin
				reason = $sformatf("%0d wrong words", wrongWords);
			end
			if (reason == "") begin
				$display("PASS %s", testName());
				passes <= passes + 1;
			end else begin
				$display("FAIL %s: %s", testName(), reason);
				fails <= fails + 1;
			end
			testIdx <= testIdx + 1;
			wrongWords <= 0;
			lowModeBad <= 1'b0;
		end
	end

endmodule

// File: tests/CpuTb.sv
`timescale 1ns/1ps

module CpuTb;
	import CpuPkg::*;

	localparam int MemWords = 256;
	localparam int RstCycles = 10;
	// Spare cycles per test and per read
	localparam int Overhead = 20;

	logic clk = 1'b0;
	logic rst;
	logic extMode;
	logic extWrite;
	word_t extAddress;
	word_t extData;
	word_t extDataOut;
	logic checkEn;
	logic testDone;
	int passCount;
	int failCount;

	// Parsed test data
	// Start lists close with a sentinel entry
	string names[$];
	int budgets[$];
	int progStart[$];
	int expStart[$];
	word_t progAddr[$];
	word_t progWord[$];
	word_t expAddr[$];
	int limit = 0;
	int cycles = 0;

	Cpu #(.MemWords(MemWords)) Cpu_inst (
		.clk(clk), .rst(rst), .extMode(extMode), .extWrite(extWrite),
		.extAddress(extAddress), .extData(extData), .extDataOut(extDataOut)
	);

	CpuChecker CpuChecker (
		.clk(clk), .extMode(extMode), .extDataOut(extDataOut), .checkEn(checkEn),
		.testDone(testDone), .passCount(passCount), .failCount(failCount)
	);

	always #20 clk = ~clk;

	// Run limit guard
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (limit > 0 && cycles >= limit) begin
			$display("Timeout: run did not finish within %0d cycles", limit);
			$display("Testbench failed");
			$finish;
		end
	end

	task automatic readTestData();
		int fd;
		int n;
		int count;
		string tag;
		string rest;
		word_t addr;
		word_t value;
		fd = $fopen("tests/cpu_testdata.txt", "r");
		if (fd == 0) begin
			$display("Could not open tests/cpu_testdata.txt");
		end else begin
			while ($fscanf(fd, "%s", tag) == 1) begin
				if (tag.substr(0, 0) == "#") begin
					n = $fgets(rest, fd);
				end else if (tag == "test") begin
					n = $fscanf(fd, "%s", rest);
					names.push_back(rest);
					progStart.push_back(progAddr.size());
					expStart.push_back(expAddr.size());
				end else if (tag == "budget") begin
					n = $fscanf(fd, "%d", count);
					budgets.push_back(count);
				end else if (tag == "prog") begin
					// Consecutive words from a start address
					n = $fscanf(fd, "%h %d", addr, count);
					for (int i = 0; i < count; i++) begin
						n = $fscanf(fd, "%h", value);
						progAddr.push_back(addr + 4 * i);
						progWord.push_back(value);
					end
				end else if (tag == "expect") begin
					n = $fscanf(fd, "%d", count);
					for (int i = 0; i < count; i++) begin
						n = $fscanf(fd, "%h %h", addr, value);
						expAddr.push_back(addr);
					end
				end
			end
			$fclose(fd);
		end
		progStart.push_back(progAddr.size());
		expStart.push_back(expAddr.size());
	endtask

	// One external write per cycle
	task automatic writeWord(word_t addr, word_t value);
		@(negedge clk);
		extAddress = addr;
		extData = value;
		extWrite = 1'b1;
	endtask

	task automatic runTest(int t);
		// Random filler so stale words of an earlier test cannot match
		for (int i = 0; i < MemWords; i++) begin
			writeWord(i * 4, $urandom);
		end
		for (int i = progStart[t]; i < progStart[t + 1]; i++) begin
			writeWord(progAddr[i], progWord[i]);
		end
		@(negedge clk);
		extWrite = 1'b0;
		rst = 1'b0;
		repeat (RstCycles) @(negedge clk);
		// Core takes the data port
		rst = 1'b1;
		extMode = 1'b0;
		repeat (budgets[t]) @(negedge clk);
		extMode = 1'b1;
		for (int i = expStart[t]; i < expStart[t + 1]; i++) begin
			extAddress = expAddr[i];
			checkEn = 1'b1;
			@(negedge clk);
		end
		checkEn = 1'b0;
		@(negedge clk);
		testDone = 1'b1;
		@(negedge clk);
		testDone = 1'b0;
	endtask

	initial begin
		rst = 1'b0;
		extMode = 1'b1;
		extWrite = 1'b0;
		extAddress = '0;
		extData = '0;
		checkEn = 1'b0;
		testDone = 1'b0;
		void'($urandom(92461));
		readTestData();
		// Fill, load, reset, budget and reads of every test
		for (int t = 0; t < names.size(); t++) begin
			limit += budgets[t] + MemWords + RstCycles + Overhead;
			limit += progStart[t + 1] - progStart[t];
			limit += Overhead * (expStart[t + 1] - expStart[t]);
		end
		for (int t = 0; t < names.size(); t++) begin
			runTest(t);
		end
		@(negedge clk);
		$display("Totals: %0d tests passed, %0d tests failed", passCount, failCount);
		if (names.size() > 0 && failCount == 0 && passCount == names.size()) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

// File: tests/cpu_testdata.txt
# test <name> | budget <cycles> | prog <hex start> <count> <hex words>
# expect <count> then <hex addr> <hex word> pairs
test alu_rtype
budget 40
prog 0 23
20010064 2002fff9 00221820 00222022 00222824 00223025 00223826 0041402a
0022482a 00015100 00025f02 ac030200 ac040204 ac050208 ac06020c ac070210
ac080214 ac090218 ac0a021c ac0b0220 08000014 00000000 00000000
expect 9
200 0000005d 204 0000006b 208 00000060 20c fffffffd
210 ffffff9d 214 00000001 218 00000000 21c 00000640
220 0000000f
test imm_mem_forward
budget 40
prog 0 18
2001ffff 2802ffff 30238001 34048000 20000005 ac010300 8c050300 00a53020
00c63820 ac020304 ac030308 ac04030c ac000310 ac060314 ac070318 0800000f
00000000 00000000
expect 7
300 ffffffff 304 00000000 308 00008001 30c 00008000
310 00000000 314 fffffffe 318 fffffffc
test branch_jump
budget 50
prog 0 25
20010001 10200005 20020002 14200004 20030003 20040004 20050005 20060006
0800000c 20070007 20080008 20090009 10210003 ac020200 ac030204 20040044
ac040208 ac05020c ac060210 ac070214 ac080218 ac09021c 08000016 00000000
00000000
expect 8
200 00000002 204 00000003 208 00000004 20c 00000000
210 00000000 214 00000007 218 00000008 21c 00000000
test ext_port
budget 12
prog 0 3
08000000 00000000 00000000
prog 100 2
deadbeef 12345678
expect 2
100 deadbeef 104 12345678

// File: verilog.f
hw/CpuPkg.sv
hw/Decoder.sv
hw/PcUnit.sv
hw/RegisterFile.sv
hw/Alu.sv
hw/UnifiedMemory.sv
hw/Cpu.sv
tests/CpuChecker.sv
tests/CpuTb.sv
